// ==== design/hough_pkg.sv ====
package hough_pkg;

    // Raw camera pixel, packed as {r, g, b} with 8 bits per channel
    localparam int PIXEL_BITS = 24;

    // Luma value out of the grayscale stage
    localparam int GRAY_BITS = 8;

    // Horizontal gradient must exceed this to mark an edge
    localparam int EDGE_THRESHOLD = 32;

    // Number of vote angles: 0, 45, 90 and 135 degrees
    localparam int THETAS = 4;

    // Width of one accumulator bin
    localparam int ACCUM_BITS = 8;

    // Q6 fixed point trig tables, 64 represents 1.0
    // Index is the angle number, in the order listed above
    localparam logic signed [7:0] COS_Q6 [0:THETAS-1] = '{
        8'sd64,
        8'sd45,
        8'sd0,
        -8'sd45
    };

    localparam logic signed [7:0] SIN_Q6 [0:THETAS-1] = '{
        8'sd0,
        8'sd45,
        8'sd64,
        8'sd45
    };

endpackage

// ==== design/pixel_fifo.sv ====
module pixel_fifo #(
    parameter int DATA_BITS = 24,
    parameter int DEPTH     = 16
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 wr_en,
    input  logic [DATA_BITS-1:0] din,
    output logic                 full,
    input  logic                 rd_en,
    output logic [DATA_BITS-1:0] dout,
    output logic                 empty
);

    localparam int PTR_BITS   = $clog2(DEPTH);
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    logic [DATA_BITS-1:0]  mem [0:DEPTH-1];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  do_wr;
    logic                  do_rd;

    assign full  = (count == COUNT_BITS'(DEPTH));
    assign empty = (count == '0);

    // Writes into a full buffer and reads from an empty one are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // First word fall through, head of the queue is always visible
    assign dout = mem[rd_ptr];

endmodule

// ==== design/grayscale.sv ====
module grayscale (
    input  logic                             clock,
    input  logic                             arst_n,
    input  logic                             in_empty,
    input  logic [hough_pkg::PIXEL_BITS-1:0] in_dout,
    input  logic                             hold,
    output logic                             in_rd_en,
    output logic                             gray_valid,
    output logic [hough_pkg::GRAY_BITS-1:0]  gray_data
);

    localparam int CH_BITS  = hough_pkg::PIXEL_BITS / 3;
    localparam int SUM_BITS = CH_BITS + 2;

    logic [CH_BITS-1:0]  red;
    logic [CH_BITS-1:0]  green;
    logic [CH_BITS-1:0]  blue;
    logic [SUM_BITS-1:0] sum;

    assign red   = in_dout[3*CH_BITS-1:2*CH_BITS];
    assign green = in_dout[2*CH_BITS-1:CH_BITS];
    assign blue  = in_dout[CH_BITS-1:0];

    // r + 2g + b, the divide by four is the slice below
    assign sum = SUM_BITS'(red) + {1'b0, green, 1'b0} + SUM_BITS'(blue);

    // Pull one pixel per cycle unless voting holds us off
    assign in_rd_en = !in_empty && !hold;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            gray_valid <= 1'b0;
        end else begin
            gray_valid <= in_rd_en;
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            gray_data <= sum[SUM_BITS-1:2];
        end
    end

endmodule

// ==== design/edge_detect.sv ====
module edge_detect #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 8
) (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              gray_valid,
    input  logic [hough_pkg::GRAY_BITS-1:0]   gray_data,
    output logic                              edge_wr_en,
    output logic [$clog2(WIDTH*HEIGHT)-1:0]   edge_wr_addr,
    output logic                              edge_wr_data,
    output logic                              frame_done
);

    localparam int ADDR_BITS = $clog2(WIDTH * HEIGHT);
    localparam int COL_BITS  = $clog2(WIDTH);
    localparam int ROW_BITS  = $clog2(HEIGHT);

    logic [COL_BITS-1:0]             col;
    logic [ROW_BITS-1:0]             row;
    logic [hough_pkg::GRAY_BITS-1:0] prev_gray;
    logic [hough_pkg::GRAY_BITS-1:0] grad;
    logic                            last_col;
    logic                            last_row;
    logic                            is_edge;

    assign last_col = (col == COL_BITS'(WIDTH - 1));
    assign last_row = (row == ROW_BITS'(HEIGHT - 1));

    // Absolute difference against the left neighbour
    assign grad = (gray_data > prev_gray) ? gray_data - prev_gray : prev_gray - gray_data;

    // Column 0 has no left neighbour, so it never marks
    assign is_edge = (col != '0) &&
                     (grad > hough_pkg::GRAY_BITS'(hough_pkg::EDGE_THRESHOLD));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            col        <= '0;
            row        <= '0;
            edge_wr_en <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            edge_wr_en <= gray_valid;
            frame_done <= gray_valid && last_col && last_row;
            if (gray_valid) begin
                if (last_col) begin
                    col <= '0;
                    row <= last_row ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // Edge bit lands at row * WIDTH + col, one cycle after the gray value
    always_ff @(posedge clock) begin
        if (gray_valid) begin
            edge_wr_addr <= ADDR_BITS'(row) * ADDR_BITS'(WIDTH) + ADDR_BITS'(col);
            edge_wr_data <= is_edge;
            prev_gray    <= gray_data;
        end
    end

endmodule

// ==== design/bram.sv ====
module bram #(
    parameter int DATA_BITS = 8,
    parameter int DEPTH     = 64
) (
    input  logic                     clock,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [DATA_BITS-1:0]     wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [DATA_BITS-1:0]     rd_data
);

    logic [DATA_BITS-1:0] mem [0:DEPTH-1];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data follows the address by one clock
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== design/hough_vote.sv ====
module hough_vote #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 8
) (
    input  logic                                            clock,
    input  logic                                            arst_n,
    input  logic                                            start,
    input  logic                                            frame_begin,
    output logic [$clog2(WIDTH*HEIGHT)-1:0]                 edge_rd_addr,
    input  logic                                            edge_rd_data,
    output logic                                            busy,
    output logic                                            done,
    input  logic [$clog2(hough_pkg::THETAS*3*WIDTH)-1:0]    accum_rd_addr,
    output logic [hough_pkg::ACCUM_BITS-1:0]                accum_rd_data
);

    localparam int RHO_RANGE  = 3 * WIDTH;
    localparam int RHO_OFFSET = WIDTH;
    localparam int BINS       = hough_pkg::THETAS * RHO_RANGE;
    localparam int BIN_BITS   = $clog2(BINS);
    localparam int PIX_BITS   = $clog2(WIDTH * HEIGHT);
    localparam int X_BITS     = $clog2(WIDTH);
    localparam int Y_BITS     = $clog2(HEIGHT);
    localparam int T_BITS     = $clog2(hough_pkg::THETAS);

    localparam logic [2:0] S_IDLE       = 3'd0;
    localparam logic [2:0] S_CLEAR      = 3'd1;
    localparam logic [2:0] S_FETCH      = 3'd2;
    localparam logic [2:0] S_VOTE_READ  = 3'd3;
    localparam logic [2:0] S_VOTE_WRITE = 3'd4;
    localparam logic [2:0] S_FINISHED   = 3'd5;

    logic [2:0]                     state;
    logic [BIN_BITS-1:0]            bin_cnt;
    logic [X_BITS-1:0]              x_cnt;
    logic [Y_BITS-1:0]              y_cnt;
    logic [T_BITS-1:0]              theta_cnt;
    logic                           fetch_phase;
    logic                           last_x;
    logic                           last_pixel;
    logic [BIN_BITS-1:0]            vote_addr;
    logic                           acc_wr_en;
    logic [BIN_BITS-1:0]            acc_wr_addr;
    logic [hough_pkg::ACCUM_BITS-1:0] acc_wr_data;
    logic [BIN_BITS-1:0]            acc_rd_addr;

    assign busy = (state == S_CLEAR) || (state == S_FETCH) ||
                  (state == S_VOTE_READ) || (state == S_VOTE_WRITE);
    assign done = (state == S_FINISHED);

    assign last_x       = (x_cnt == X_BITS'(WIDTH - 1));
    assign last_pixel   = last_x && (y_cnt == Y_BITS'(HEIGHT - 1));
    assign edge_rd_addr = PIX_BITS'(y_cnt) * PIX_BITS'(WIDTH) + PIX_BITS'(x_cnt);

    // rho = (x*cos + y*sin) >>> 6, shifted up so the bin index is never negative
    // 16 bits of sum covers frames well beyond the default size
    always_comb begin
        logic signed [15:0] x_s;
        logic signed [15:0] y_s;
        logic signed [15:0] rho_sum;
        logic signed [15:0] rho_bin;
        x_s       = 16'(x_cnt);
        y_s       = 16'(y_cnt);
        rho_sum   = x_s * 16'(hough_pkg::COS_Q6[theta_cnt]) +
                    y_s * 16'(hough_pkg::SIN_Q6[theta_cnt]);
        rho_bin   = (rho_sum >>> 6) + 16'(RHO_OFFSET);
        vote_addr = BIN_BITS'(int'(theta_cnt) * RHO_RANGE + int'(rho_bin));
    end

    // Write port is shared by the clear sweep and the increment
    assign acc_wr_en   = (state == S_CLEAR) || (state == S_VOTE_WRITE);
    assign acc_wr_addr = (state == S_CLEAR) ? bin_cnt : vote_addr;
    assign acc_wr_data = (state == S_CLEAR) ? '0 : accum_rd_data + 1'b1;
    assign acc_rd_addr = busy ? vote_addr : accum_rd_addr;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_IDLE;
            bin_cnt     <= '0;
            x_cnt       <= '0;
            y_cnt       <= '0;
            theta_cnt   <= '0;
            fetch_phase <= 1'b0;
        end else begin
            case (state)
                S_IDLE, S_FINISHED: begin
                    if (start) begin
                        state       <= S_CLEAR;
                        bin_cnt     <= '0;
                        x_cnt       <= '0;
                        y_cnt       <= '0;
                        fetch_phase <= 1'b0;
                    end else if (frame_begin) begin
                        state <= S_IDLE;
                    end
                end
                S_CLEAR: begin
                    if (bin_cnt == BIN_BITS'(BINS - 1)) begin
                        state <= S_FETCH;
                    end else begin
                        bin_cnt <= bin_cnt + 1'b1;
                    end
                end
                S_FETCH: begin
                    // Phase 0 presents the address, phase 1 sees the edge bit
                    fetch_phase <= !fetch_phase;
                    if (fetch_phase) begin
                        if (edge_rd_data) begin
                            theta_cnt <= '0;
                            state     <= S_VOTE_READ;
                        end else if (last_pixel) begin
                            state <= S_FINISHED;
                        end else begin
                            x_cnt <= last_x ? '0 : x_cnt + 1'b1;
                            y_cnt <= last_x ? y_cnt + 1'b1 : y_cnt;
                        end
                    end
                end
                S_VOTE_READ: begin
                    state <= S_VOTE_WRITE;
                end
                S_VOTE_WRITE: begin
                    if (theta_cnt != T_BITS'(hough_pkg::THETAS - 1)) begin
                        theta_cnt <= theta_cnt + 1'b1;
                        state     <= S_VOTE_READ;
                    end else if (last_pixel) begin
                        state <= S_FINISHED;
                    end else begin
                        x_cnt <= last_x ? '0 : x_cnt + 1'b1;
                        y_cnt <= last_x ? y_cnt + 1'b1 : y_cnt;
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    bram #(
        .DATA_BITS(hough_pkg::ACCUM_BITS),
        .DEPTH(BINS)
    ) u_accum (
        .clock(clock),
        .wr_en(acc_wr_en),
        .wr_addr(acc_wr_addr),
        .wr_data(acc_wr_data),
        .rd_addr(acc_rd_addr),
        .rd_data(accum_rd_data)
    );

endmodule

// ==== design/hough_top.sv ====
module hough_top #(
    parameter int WIDTH      = 8,
    parameter int HEIGHT     = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                         clock,
    input  logic                                         arst_n,
    // Pixel input
    input  logic                                         image_wr_en,
    input  logic [hough_pkg::PIXEL_BITS-1:0]             image_din,
    output logic                                         image_full,
    // Results
    output logic                                         done,
    input  logic [$clog2(hough_pkg::THETAS*3*WIDTH)-1:0] accum_rd_addr,
    output logic [hough_pkg::ACCUM_BITS-1:0]             accum_rd_data
);

    localparam int PIX_BITS = $clog2(WIDTH * HEIGHT);

    // FIFO to grayscale
    logic [hough_pkg::PIXEL_BITS-1:0] fifo_dout;
    logic                             fifo_empty;
    logic                             fifo_rd_en;

    // Grayscale to edge stage
    logic                             gray_valid;
    logic [hough_pkg::GRAY_BITS-1:0]  gray_data;

    // Edge map write and read sides
    logic                             edge_wr_en;
    logic [PIX_BITS-1:0]              edge_wr_addr;
    logic                             edge_wr_data;
    logic                             frame_done;
    logic [PIX_BITS-1:0]              edge_rd_addr;
    logic                             edge_rd_data;

    logic                             vote_busy;
    logic                             gray_hold;

    // Also stall on the frame_done cycle, so at most the next frame's first
    // pixel (column 0, never an edge) can reach the edge map before voting
    assign gray_hold = vote_busy || frame_done;

    pixel_fifo #(
        .DATA_BITS(hough_pkg::PIXEL_BITS),
        .DEPTH(FIFO_DEPTH)
    ) u_image_fifo (
        .clock(clock),
        .arst_n(arst_n),
        .wr_en(image_wr_en),
        .din(image_din),
        .full(image_full),
        .rd_en(fifo_rd_en),
        .dout(fifo_dout),
        .empty(fifo_empty)
    );

    grayscale u_grayscale (
        .clock(clock),
        .arst_n(arst_n),
        .in_empty(fifo_empty),
        .in_dout(fifo_dout),
        .hold(gray_hold),
        .in_rd_en(fifo_rd_en),
        .gray_valid(gray_valid),
        .gray_data(gray_data)
    );

    edge_detect #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT)
    ) u_edge_detect (
        .clock(clock),
        .arst_n(arst_n),
        .gray_valid(gray_valid),
        .gray_data(gray_data),
        .edge_wr_en(edge_wr_en),
        .edge_wr_addr(edge_wr_addr),
        .edge_wr_data(edge_wr_data),
        .frame_done(frame_done)
    );

    bram #(
        .DATA_BITS(1),
        .DEPTH(WIDTH * HEIGHT)
    ) u_edge_bram (
        .clock(clock),
        .wr_en(edge_wr_en),
        .wr_addr(edge_wr_addr),
        .wr_data(edge_wr_data),
        .rd_addr(edge_rd_addr),
        .rd_data(edge_rd_data)
    );

    hough_vote #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT)
    ) u_hough_vote (
        .clock(clock),
        .arst_n(arst_n),
        .start(frame_done),
        .frame_begin(fifo_rd_en),
        .edge_rd_addr(edge_rd_addr),
        .edge_rd_data(edge_rd_data),
        .busy(vote_busy),
        .done(done),
        .accum_rd_addr(accum_rd_addr),
        .accum_rd_data(accum_rd_data)
    );

endmodule

// ==== tests/tb_hough_top.sv ====
module tb_hough_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WIDTH         = 8;
    localparam int HEIGHT        = 8;
    localparam int FIFO_DEPTH    = 16;
    localparam int PIXELS        = WIDTH * HEIGHT;
    localparam int FRAMES        = 4;
    localparam int RHO_RANGE     = 3 * WIDTH;
    localparam int RHO_OFFSET    = WIDTH;
    localparam int BINS          = hough_pkg::THETAS * RHO_RANGE;
    localparam int ACC_ADDR_BITS = $clog2(BINS);
    // Four frames of at most about 900 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 6000;

    logic                              clock;
    logic                              arst_n;
    logic                              image_wr_en;
    logic [hough_pkg::PIXEL_BITS-1:0]  image_din;
    logic                              image_full;
    logic                              done;
    logic [ACC_ADDR_BITS-1:0]          accum_rd_addr;
    logic [hough_pkg::ACCUM_BITS-1:0]  accum_rd_data;

    int   seed = 32'hc802;
    int   cycle_count = 0;
    logic first_frame_sent;

    // Stimulus frames and their expected accumulators
    logic [hough_pkg::PIXEL_BITS-1:0] frames [0:FRAMES-1][0:PIXELS-1];
    logic [hough_pkg::ACCUM_BITS-1:0] expected [0:FRAMES-1][0:BINS-1];

    hough_top #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_dut (
        .clock(clock),
        .arst_n(arst_n),
        .image_wr_en(image_wr_en),
        .image_din(image_din),
        .image_full(image_full),
        .done(done),
        .accum_rd_addr(accum_rd_addr),
        .accum_rd_data(accum_rd_data)
    );

    always #2 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("Regression failed");
        $display("%s", reason);
        $fatal(1, "Run stopped at cycle %0d", cycle_count);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
            else abort_run($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, no result after %0d clock cycles", cycle_count));
        end
    end

    // No result may appear before a whole first frame went in
    first_done_check: assert property (@(posedge clock) disable iff (!arst_n)
        !first_frame_sent |-> !done)
        else abort_run("done rose before the first frame was complete");

    // done holds until a pixel is taken from the FIFO and then drops
    done_clear_check: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> (done != $past(u_dut.fifo_rd_en)))
        else abort_run("done did not follow the FIFO read that begins a new frame");

    // Dark left half, bright right half, step between columns 3 and 4
    task automatic fill_step(input int f);
        int i;
        for (i = 0; i < PIXELS; i++) begin
            frames[f][i] = ((i % WIDTH) < 4) ? 24'h101010 : 24'hc0c0c0;
        end
    endtask

    task automatic fill_random(input int f);
        logic [31:0] word;
        int i;
        for (i = 0; i < PIXELS; i++) begin
            word = $random(seed);
            frames[f][i] = word[hough_pkg::PIXEL_BITS-1:0];
        end
    endtask

    // Bright above the main diagonal, edges run at 45 degrees
    task automatic fill_diagonal(input int f);
        int i;
        for (i = 0; i < PIXELS; i++) begin
            frames[f][i] = ((i % WIDTH) > (i / WIDTH)) ? 24'he0e0e0 : 24'h202020;
        end
    endtask

    function automatic int gray_of(input logic [hough_pkg::PIXEL_BITS-1:0] p);
        return (int'(p[23:16]) + 2 * int'(p[15:8]) + int'(p[7:0])) / 4;
    endfunction

    task automatic build_model(input int f);
        int gray_val [0:PIXELS-1];
        int x;
        int y;
        int t;
        int i;
        int diff;
        int rho;
        for (i = 0; i < BINS; i++) begin
            expected[f][i] = '0;
        end
        for (i = 0; i < PIXELS; i++) begin
            gray_val[i] = gray_of(frames[f][i]);
        end
        for (y = 0; y < HEIGHT; y++) begin
            for (x = 1; x < WIDTH; x++) begin
                i    = y * WIDTH + x;
                diff = gray_val[i] - gray_val[i-1];
                if (diff < 0) begin
                    diff = -diff;
                end
                if (diff > hough_pkg::EDGE_THRESHOLD) begin
                    for (t = 0; t < hough_pkg::THETAS; t++) begin
                        rho = ((x * int'(hough_pkg::COS_Q6[t]) +
                                y * int'(hough_pkg::SIN_Q6[t])) >>> 6) + RHO_OFFSET;
                        expected[f][t*RHO_RANGE+rho] = expected[f][t*RHO_RANGE+rho] + 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic send_pixels(input int f, input int first, input int count);
        int i;
        for (i = first; i < first + count; i++) begin
            @(negedge clock);
            image_wr_en = 1'b0;
            while (image_full) begin
                @(negedge clock);
            end
            image_wr_en = 1'b1;
            image_din   = frames[f][i];
        end
        @(negedge clock);
        image_wr_en = 1'b0;
    endtask

    // done can be a single cycle when pixels are already queued
    task automatic wait_done();
        while (!done) begin
            @(negedge clock);
        end
    endtask

    task automatic read_accum(input int f);
        int a;
        for (a = 0; a <= BINS; a++) begin
            @(negedge clock);
            if (a > 0) begin
                check_value($sformatf("accum_rd_data[bin %0d]", a - 1),
                            32'(accum_rd_data), 32'(expected[f][a-1]));
            end
            if (a < BINS) begin
                accum_rd_addr = ACC_ADDR_BITS'(a);
            end
        end
    endtask

    // Queue the head of frame f while the previous frame is being voted
    task automatic fill_fifo_while_busy(input int f);
        int i;
        while (!u_dut.vote_busy) begin
            @(negedge clock);
        end
        for (i = 0; i < FIFO_DEPTH; i++) begin
            @(negedge clock);
            assert (!image_full)
                else abort_run($sformatf("image_full rose after only %0d queued writes", i));
            image_wr_en = 1'b1;
            image_din   = frames[f][i];
        end
        @(negedge clock);
        image_wr_en = 1'b0;
        check_value("image_full", 32'(image_full), 32'd1);
        // Extra word into a full FIFO, must be dropped
        image_wr_en = 1'b1;
        image_din   = 24'hffffff;
        @(negedge clock);
        image_wr_en = 1'b0;
        check_value("image_full", 32'(image_full), 32'd1);
        assert (u_dut.vote_busy)
            else abort_run("Voting ended before the queued writes were finished");
    endtask

    initial begin
        clock            = 1'b0;
        arst_n           = 1'b0;
        image_wr_en      = 1'b0;
        image_din        = '0;
        accum_rd_addr    = '0;
        first_frame_sent = 1'b0;

        fill_step(0);
        fill_random(1);
        fill_random(2);
        fill_diagonal(3);
        for (int f = 0; f < FRAMES; f++) begin
            build_model(f);
        end

        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        check_value("done", 32'(done), 32'd0);
        check_value("image_full", 32'(image_full), 32'd0);
        check_value("edge_wr_en", 32'(u_dut.edge_wr_en), 32'd0);

        // Vertical step frame
        send_pixels(0, 0, PIXELS);
        first_frame_sent = 1'b1;
        wait_done();
        read_accum(0);

        // done holds until the first pixel of the next frame is taken
        check_value("done", 32'(done), 32'd1);
        send_pixels(1, 0, 1);
        repeat (2) @(negedge clock);
        check_value("done", 32'(done), 32'd0);
        send_pixels(1, 1, PIXELS - 1);
        wait_done();
        read_accum(1);

        // Back to back frames, the second one starts under back-pressure
        send_pixels(2, 0, PIXELS);
        fill_fifo_while_busy(3);
        wait_done();
        read_accum(2);
        send_pixels(3, FIFO_DEPTH, PIXELS - FIFO_DEPTH);
        wait_done();
        read_accum(3);
        check_value("image_full", 32'(image_full), 32'd0);

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== src.f ====
design/hough_pkg.sv
design/pixel_fifo.sv
design/grayscale.sv
design/edge_detect.sv
design/bram.sv
design/hough_vote.sv
design/hough_top.sv
tests/tb_hough_top.sv

// ==== Makefile ====
# Verilator flow for the Hough line-detection project

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_hough_top
RTL_TOP    ?= hough_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
RUN_ARGS   ?=

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

# Exit status of the simulation binary is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
